/* build.f */
+incdir+verilog
verilog/routerPkg.sv
verilog/flitIf.sv
verilog/inputStage.sv
verilog/holdTimer.sv
verilog/switchArbiter.sv
verilog/crossbarStage.sv
verilog/outputPortTop.sv
testbench/outputPort_asserts.sv
testbench/tbOutputPort.sv

/* run.sh */
#!/bin/sh
# build the simulation, run it and scan the log
verilator --binary --timing --assert -Wno-fatal --top-module tbOutputPort -f build.f \
  -o simOutputPort || exit 1
./obj_dir/simOutputPort > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log && exit 0 || exit 1

/* testbench/outputPort_asserts.sv */
`timescale 1ns/1ps

module outputPortAsserts
  import routerPkg::*;
(
  input logic clk,
  input logic rst,
  input grant_t grant,
  input grant_t reqVec
);

  int failCount = 0;

  // at most one port owns the output
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
  else
  begin
    failCount++;
    $error("grant 0x%0h has more than one bit set", grant);
  end

  // synchronous reset, grant is clear on the edge after rst is seen
  grantResetClear: assert property (@(posedge clk) rst |=> grant == '0)
  else
  begin
    failCount++;
    $error("grant 0x%0h not cleared by reset", grant);
  end

  // the state follows the req levels of the cycle before
  grantNeedsReq: assert property (@(posedge clk) disable iff (rst)
    (grant & ~$past(reqVec)) == '0)
  else
  begin
    failCount++;
    $error("grant 0x%0h given to a port without req", grant);
  end

endmodule

bind switchArbiter outputPortAsserts arbAsserts
(
  .clk(clk),
  .rst(rst),
  .grant(grant),
  .reqVec(reqVec)
);

/* testbench/tbOutputPort.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module tbOutputPort
  import routerPkg::*;
();

  localparam int PORT_L = 0;
  localparam int PORT_N = 1;
  localparam int PORT_E = 2;
  localparam int PORT_W = 3;
  localparam int PORT_S = 4;

  logic clk;
  logic rst;
  logic [`NUM_PORTS-1:0] inValid;
  flit_t inFlit [`NUM_PORTS];
  grant_t grant;
  logic outValid;
  flit_t outFlit;
  portId_t outPort;

  int errorCount;
  int timeoutCount;
  logic [31:0] lcgState;

  outputPortTop dut
  (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inFlit(inFlit),
    .grant(grant),
    .outValid(outValid),
    .outFlit(outFlit),
    .outPort(outPort)
  );

  always #5 clk = ~clk;

  function automatic logic [12:0] randomPayload();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[28:16];
  endfunction

  function automatic flit_t makeFlit(input flitType_t kind, input logic [12:0] payload);
    return {kind, payload};
  endfunction

  function automatic grant_t portMask(input int p);
    return grant_t'(1 << p);
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    assert (actual === expected)
    else
    begin
      errorCount++;
      $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  // every cycle starts with all strobes low, sendFlit raises the ones in use
  task automatic nextCycle();
    @(posedge clk);
    inValid <= '0;
  endtask

  task automatic sendFlit(input int p, input flit_t f);
    inValid[p] <= 1'b1;
    inFlit[p] <= f;
  endtask

  task automatic sendHeader(input int p, input pktLength_t len);
    sendFlit(p, makeFlit(FLIT_HEADER, {1'b0, len}));
  endtask

  task automatic waitGrant(input grant_t expected, input int limit);
    int cycles;
    cycles = 0;
    nextCycle();
    @(negedge clk);
    while (grant !== expected && cycles < limit)
    begin
      nextCycle();
      @(negedge clk);
      cycles++;
    end
    if (grant !== expected)
    begin
      timeoutCount++;
      $display("grant never became 0x%0h within %0d cycles", expected, limit);
    end
  endtask

  // body flits and a tail on one port, each expected at the output two cycles later
  task automatic streamPacket(input int port, input int count, input int noisePort);
    flit_t sent [$];
    flit_t f;
    for (int m = 0; m < count + 2; m++)
    begin
      nextCycle();
      if (m < count)
      begin
        f = makeFlit((m == count - 1) ? FLIT_TAIL : FLIT_BODY, randomPayload());
        sent.push_back(f);
        sendFlit(port, f);
        if (noisePort >= 0)
          sendFlit(noisePort, makeFlit(FLIT_BODY, randomPayload()));
      end
      @(negedge clk);
      if (m < 2)
      begin
        checkValue("outValid", outValid, 1'b0);
      end
      else
      begin
        checkValue("outValid", outValid, 1'b1);
        checkValue("outFlit", outFlit, sent[m - 2]);
        checkValue("outPort", outPort, port);
      end
    end
  endtask

  task automatic testResetState();
    for (int m = 0; m < 3; m++)
    begin
      nextCycle();
      @(negedge clk);
      checkValue("grant", grant, '0);
      checkValue("outValid", outValid, 1'b0);
    end
  endtask

  task automatic testSinglePacket();
    nextCycle();
    sendHeader(PORT_N, 12'd12);
    waitGrant(portMask(PORT_N), 6);
    streamPacket(PORT_N, 6, -1);
    waitGrant('0, 6);
  endtask

  task automatic testFixedPriority();
    int cycles;
    cycles = 0;
    nextCycle();
    sendHeader(PORT_L, 12'd2);
    sendHeader(PORT_S, 12'd2);
    nextCycle();
    @(negedge clk);
    while (grant == '0 && cycles < 6)
    begin
      nextCycle();
      @(negedge clk);
      cycles++;
    end
    checkValue("grant", grant, portMask(PORT_L));
    waitGrant(portMask(PORT_S), 6);
    nextCycle();
    sendFlit(PORT_L, makeFlit(FLIT_TAIL, randomPayload()));
    sendFlit(PORT_S, makeFlit(FLIT_TAIL, randomPayload()));
    waitGrant('0, 8);
  endtask

  task automatic testHoldLimit();
    int held;
    nextCycle();
    sendHeader(PORT_E, 12'd3);
    sendHeader(PORT_W, 12'd3);
    waitGrant(portMask(PORT_E), 6);
    held = 1;
    // E keeps its request up the whole time
    while (grant == portMask(PORT_E) && held < 10)
    begin
      nextCycle();
      sendFlit(PORT_E, makeFlit(FLIT_BODY, randomPayload()));
      @(negedge clk);
      if (grant == portMask(PORT_E))
        held++;
    end
    checkValue("heldCycles", held, 4);
    checkValue("grant", grant, portMask(PORT_W));
    nextCycle();
    sendFlit(PORT_E, makeFlit(FLIT_TAIL, randomPayload()));
    sendFlit(PORT_W, makeFlit(FLIT_TAIL, randomPayload()));
    waitGrant('0, 12);
  endtask

  task automatic testRotation();
    for (int m = 0; m < 12; m++)
    begin
      nextCycle();
      for (int p = 0; p < `NUM_PORTS; p++)
        sendHeader(p, '0);
      @(negedge clk);
      if (m < 2)
        checkValue("grant", grant, '0);
      else
        checkValue("grant", grant, portMask((m - 2) % `NUM_PORTS));
    end
    waitGrant('0, 8);
  endtask

  task automatic testEarlyRelease();
    nextCycle();
    sendHeader(PORT_L, 12'd20);
    sendHeader(PORT_N, 12'd20);
    waitGrant(portMask(PORT_L), 6);
    // N keeps sending while L owns the output
    streamPacket(PORT_L, 4, PORT_N);
    waitGrant(portMask(PORT_N), 3);
    checkValue("outValid", outValid, 1'b0);
    nextCycle();
    sendFlit(PORT_N, makeFlit(FLIT_TAIL, randomPayload()));
    waitGrant('0, 6);
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
      inFlit[p] = '0;
    errorCount = 0;
    timeoutCount = 0;
    lcgState = 32'd4283;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    testResetState();
    testSinglePacket();
    testFixedPriority();
    testHoldLimit();
    testRotation();
    testEarlyRelease();
    $display("summary: %0d value errors, %0d timeouts, %0d assertion failures",
             errorCount, timeoutCount, dut.arbiterInst.arbAsserts.failCount);
    if (errorCount == 0 && timeoutCount == 0 && dut.arbiterInst.arbAsserts.failCount == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* verilog/crossbarStage.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module crossbarStage
  import routerPkg::*;
(
  input logic clk,
  input logic rst,
  flitIf.sink ports [`NUM_PORTS],
  input grant_t grant,
  output logic outValid,
  output flit_t outFlit,
  output portId_t outPort
);

  grant_t validVec;
  flit_t flitVec [`NUM_PORTS];
  logic selValid;
  flit_t selFlit;
  portId_t selPort;

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genPort
    assign validVec[i] = ports[i].valid;
    assign flitVec[i] = ports[i].flit;
  end

  // grant is one-hot, so at most one port is selected
  always_comb
  begin
    selValid = 1'b0;
    selFlit = '0;
    selPort = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (grant[i])
      begin
        selValid = validVec[i];
        selFlit = flitVec[i];
        selPort = portId_t'(i);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selValid;
  end

  // flit and port index hold their last value between packets
  always_ff @(posedge clk)
  begin
    if (selValid)
    begin
      outFlit <= selFlit;
      outPort <= selPort;
    end
  end

endmodule

/* verilog/flitIf.sv */
`timescale 1ns/1ps

interface flitIf
  import routerPkg::*;
();

  logic valid;
  flit_t flit;
  // level held from header to tail
  logic req;
  // length of the last header seen on this port
  pktLength_t length;

  modport source
  (
    output valid,
    output flit,
    output req,
    output length
  );

  modport sink
  (
    input valid,
    input flit,
    input req,
    input length
  );

endinterface

/* verilog/holdTimer.sv */
`timescale 1ns/1ps

module holdTimer
  import routerPkg::*;
(
  input logic clk,
  input logic rst,
  input pktLength_t length,
  input logic run,
  output logic timesUp
);

  // cycles the port has held the grant so far
  pktLength_t count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (!run)
    begin
      // restart for the next grant
      count <= '0;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  // count starts at 0 on entry, so a port holds for length+1 cycles
  assign timesUp = (count == length);

endmodule

/* verilog/inputStage.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module inputStage
  import routerPkg::*;
(
  input logic clk,
  input logic rst,
  input logic inValid,
  input flit_t inFlit,
  flitIf.source port
);

  flitType_t inType;
  flitType_t regType;
  logic validReg;
  flit_t flitReg;
  logic reqReg;
  pktLength_t lengthReg;
  logic packetDone;

  assign inType = inFlit[`FLIT_WIDTH-1 -: $bits(flitType_t)];
  assign regType = flitReg[`FLIT_WIDTH-1 -: $bits(flitType_t)];

  // end of packet seen in the registered flit
  always_comb
  begin
    packetDone = 1'b0;
    if (validReg)
    begin
      case (regType)
        FLIT_HEADER: packetDone = (lengthReg == '0);
        FLIT_BODY: packetDone = 1'b0;
        FLIT_TAIL: packetDone = 1'b1;
        default: packetDone = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      validReg <= 1'b0;
      reqReg <= 1'b0;
    end
    else
    begin
      validReg <= inValid;
      // a new header wins over the end of the previous packet
      if (inValid && inType == FLIT_HEADER)
        reqReg <= 1'b1;
      else if (packetDone)
        reqReg <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    flitReg <= inFlit;
    if (inValid && inType == FLIT_HEADER)
      lengthReg <= inFlit[`LEN_WIDTH-1:0];
  end

  assign port.valid = validReg;
  assign port.flit = flitReg;
  assign port.req = reqReg;
  assign port.length = lengthReg;

endmodule

/* verilog/outputPortTop.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module outputPortTop
  import routerPkg::*;
(
  input logic clk,
  input logic rst,
  input logic [`NUM_PORTS-1:0] inValid,
  input flit_t inFlit [`NUM_PORTS],
  output grant_t grant,
  output logic outValid,
  output flit_t outFlit,
  output portId_t outPort
);

  // one bundle per input port, index order L, N, E, W, S
  flitIf portBus [`NUM_PORTS] ();

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genInput
    inputStage inputStageInst
    (
      .clk(clk),
      .rst(rst),
      .inValid(inValid[i]),
      .inFlit(inFlit[i]),
      .port(portBus[i])
    );
  end

  switchArbiter arbiterInst
  (
    .clk(clk),
    .rst(rst),
    .ports(portBus),
    .grant(grant)
  );

  crossbarStage crossbarInst
  (
    .clk(clk),
    .rst(rst),
    .ports(portBus),
    .grant(grant),
    .outValid(outValid),
    .outFlit(outFlit),
    .outPort(outPort)
  );

endmodule

/* verilog/routerPkg.sv */
`include "router_config.svh"

package routerPkg;

  typedef logic [`FLIT_WIDTH-1:0] flit_t;
  typedef logic [2:0] flitType_t;
  typedef logic [`LEN_WIDTH-1:0] pktLength_t;
  typedef logic [`NUM_PORTS-1:0] grant_t;
  typedef logic [2:0] portId_t;

  // flit type codes
  localparam flitType_t FLIT_HEADER = 3'd1;
  localparam flitType_t FLIT_BODY = 3'd2;
  localparam flitType_t FLIT_TAIL = 3'd4;

  // one-hot, bit 0 is idle and bits 5:1 follow the grant order
  typedef enum logic [`NUM_PORTS:0] {
    IDLE    = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } arbState_t;

endpackage

/* verilog/router_config.svh */
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// input ports in the order L, N, E, W, S
`define NUM_PORTS 5

// bits per flit, type in the top three bits
`define FLIT_WIDTH 16

// hold limit field in the low bits of a header payload
`define LEN_WIDTH 12

`endif

/* verilog/switchArbiter.sv */
`timescale 1ns/1ps
`include "router_config.svh"

module switchArbiter
  import routerPkg::*;
(
  input logic clk,
  input logic rst,
  flitIf.sink ports [`NUM_PORTS],
  output grant_t grant
);

  arbState_t curState;
  arbState_t nextState;
  grant_t reqVec;
  grant_t timesUp;
  grant_t run;
  pktLength_t lenVec [`NUM_PORTS];

  // state that grants port idx
  function automatic arbState_t grantState(input int idx);
    logic [`NUM_PORTS:0] oneHot;
    oneHot = {{`NUM_PORTS{1'b0}}, 1'b1} << (idx + 1);
    return arbState_t'(oneHot);
  endfunction

  // first requester among count ports from first on, wrapping after S
  function automatic arbState_t pickNext(input grant_t reqs, input int first, input int count);
    arbState_t pick;
    int idx;
    pick = IDLE;
    // scan backwards so the earliest port in the order wins
    for (int k = `NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (first + k) % `NUM_PORTS;
      if (k < count && reqs[idx])
        pick = grantState(idx);
    end
    return pick;
  endfunction

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genPort
    assign reqVec[i] = ports[i].req;
    assign lenVec[i] = ports[i].length;

    holdTimer timerInst
    (
      .clk(clk),
      .rst(rst),
      .length(lenVec[i]),
      .run(run[i]),
      .timesUp(timesUp[i])
    );
  end

  always_comb
  begin
    run = '0;
    nextState = IDLE;
    if (curState == IDLE)
    begin
      // from idle the order starts at L
      nextState = pickNext(reqVec, 0, `NUM_PORTS);
    end
    else
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        if (curState == grantState(p))
        begin
          if (reqVec[p] && !timesUp[p])
          begin
            // keep the output, timer counts only while staying
            run[p] = 1'b1;
            nextState = curState;
          end
          else
          begin
            // the current port is not a candidate, others after it are
            nextState = pickNext(reqVec, p + 1, `NUM_PORTS - 1);
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      curState <= IDLE;
    else
      curState <= nextState;
  end

  // drop the idle bit, the rest is already one-hot per port
  assign grant = curState[`NUM_PORTS:1];

endmodule
